// File: vec_pkg.sv
`default_nettype none

package vec_pkg;

  // one vector register
  localparam int vlen = 256;

  // one beat on the register file port
  localparam int beat_width = 64;

  // byte enables per beat
  localparam int beat_bytes = beat_width / 8;

  // beats per register, walked in order 0 to 3
  localparam int num_beats = vlen / beat_width;
  localparam int beat_idx_width = 2;

  // 32 registers
  localparam int reg_addr_width = 5;

  // peers sharing the single port
  localparam int num_clients = 2;
  localparam int client_xfer = 0;
  localparam int client_arith = 1;

endpackage

`default_nettype wire

// File: vcmd_pkg.sv
`default_nettype none

package vcmd_pkg;

  typedef enum logic [2:0] {
    op_load  = 3'd0,
    op_store = 3'd1,
    op_add   = 3'd2,
    op_sub   = 3'd3
  } vop_e;

  typedef enum logic {
    lane8  = 1'b0,
    lane32 = 1'b1
  } lane_e;

  // add / sub format
  typedef struct packed {
    vop_e                               op;
    logic [vec_pkg::reg_addr_width-1:0] vd;
    logic [vec_pkg::reg_addr_width-1:0] vs1;
    logic [vec_pkg::reg_addr_width-1:0] vs2;
    lane_e                              lane;
    logic [4:0]                         spare;
  } vcmd_arith_t;

  // load / store format, vd is the source register on a store
  typedef struct packed {
    vop_e                               op;
    logic [vec_pkg::reg_addr_width-1:0] vd;
    logic [7:0]                         byte_mask;
    logic [7:0]                         spare;
  } vcmd_mem_t;

  // op sits in the top 3 bits of both views
  typedef union packed {
    vcmd_arith_t arith;
    vcmd_mem_t   mem;
  } vcmd_u;

endpackage

`default_nettype wire

// File: vec_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module vec_regfile (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               en,
  input  logic                               rw,
  input  logic [vec_pkg::reg_addr_width-1:0] addr,
  input  logic [vec_pkg::beat_bytes-1:0]     byte_en,
  input  logic [vec_pkg::beat_width-1:0]     wr_data,
  output logic [vec_pkg::beat_width-1:0]     rd_data,
  output logic                               active
);
  import vec_pkg::*;

  typedef enum logic [1:0] {
    rf_idle    = 2'b00,
    rf_busy_rd = 2'b01,
    rf_busy_wr = 2'b10
  } rf_state_e;

  rf_state_e                 state_q;
  logic [reg_addr_width-1:0] cur_reg_q;
  logic [beat_idx_width-1:0] cur_idx_q;
  logic [reg_addr_width-1:0] row;
  logic [beat_idx_width-1:0] idx;
  logic                      wr_beat;
  logic                      rd_beat;

  // storage, no data reset
  logic [num_beats-1:0][beat_width-1:0] mem [1 << reg_addr_width];

  // beat 0 goes straight from the port, later beats from the latched values
  assign row = en ? addr : cur_reg_q;
  assign idx = en ? '0 : cur_idx_q;

  assign wr_beat = (en && rw) || (state_q == rf_busy_wr);
  assign rd_beat = (en && !rw) || (state_q == rf_busy_rd);

  // high for beats 1 to 3
  assign active = (state_q != rf_idle);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q   <= rf_idle;
      cur_reg_q <= '0;
      cur_idx_q <= '0;
    end else begin
      case (state_q)
        rf_idle: begin
          if (en) begin
            state_q   <= rw ? rf_busy_wr : rf_busy_rd;
            cur_reg_q <= addr;
            cur_idx_q <= beat_idx_width'(1);
          end
        end
        rf_busy_rd, rf_busy_wr: begin
          // index wraps back to 0 after the last beat
          cur_idx_q <= cur_idx_q + 1'b1;
          if (cur_idx_q == beat_idx_width'(num_beats - 1)) begin
            state_q <= rf_idle;
          end
        end
        default: state_q <= rf_idle;
      endcase
    end
  end

  // masked write, registered read
  always_ff @(posedge clk) begin
    if (wr_beat) begin
      for (int b = 0; b < beat_bytes; b++) begin
        if (byte_en[b]) begin
          mem[row][idx][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
    if (rd_beat) begin
      rd_data <= mem[row][idx];
    end
  end

endmodule

`default_nettype wire

// File: vec_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module vec_port_arbiter (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               req [vec_pkg::num_clients],
  input  logic                               rw [vec_pkg::num_clients],
  input  logic [vec_pkg::reg_addr_width-1:0] addr [vec_pkg::num_clients],
  input  logic [vec_pkg::beat_bytes-1:0]     byte_en [vec_pkg::num_clients],
  input  logic [vec_pkg::beat_width-1:0]     wr_data [vec_pkg::num_clients],
  output logic                               gnt [vec_pkg::num_clients],
  output logic                               rf_en,
  output logic                               rf_rw,
  output logic [vec_pkg::reg_addr_width-1:0] rf_addr,
  output logic [vec_pkg::beat_bytes-1:0]     rf_byte_en,
  output logic [vec_pkg::beat_width-1:0]     rf_wr_data,
  input  logic                               rf_active
);
  import vec_pkg::*;

  logic held_q;
  logic first_q;
  // current owner, also the last winner for round robin
  logic owner_q;
  logic winner;
  logic any_req;
  logic burst_over;
  logic can_grant;

  assign any_req = req[client_xfer] || req[client_arith];

  // on a tie the client that lost last time goes first
  always_comb begin
    if (req[client_xfer] && req[client_arith]) begin
      winner = !owner_q;
    end else if (req[client_arith]) begin
      winner = 1'(client_arith);
    end else begin
      winner = 1'(client_xfer);
    end
  end

  // regfile goes idle again after beat 3
  assign burst_over = held_q && !first_q && !rf_active;
  assign can_grant  = !held_q || burst_over;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      held_q  <= 1'b0;
      first_q <= 1'b0;
      // so that xfer wins the first tie
      owner_q <= 1'(client_arith);
    end else begin
      first_q <= 1'b0;
      if (can_grant && any_req) begin
        held_q  <= 1'b1;
        first_q <= 1'b1;
        owner_q <= winner;
      end else if (burst_over) begin
        held_q <= 1'b0;
      end
    end
  end

  // grant covers exactly beats 0 to 3
  always_comb begin
    for (int i = 0; i < num_clients; i++) begin
      gnt[i] = held_q && (first_q || rf_active) && (owner_q == 1'(i));
    end
  end

  assign rf_en      = first_q;
  assign rf_rw      = rw[owner_q];
  assign rf_addr    = addr[owner_q];
  assign rf_byte_en = byte_en[owner_q];
  assign rf_wr_data = wr_data[owner_q];

endmodule

`default_nettype wire

// File: vec_xfer_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vec_xfer_unit (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  vcmd_pkg::vcmd_mem_t                cmd,
  output logic                               done,
  output logic                               req,
  output logic                               rw,
  output logic [vec_pkg::reg_addr_width-1:0] addr,
  output logic [vec_pkg::beat_bytes-1:0]     byte_en,
  output logic [vec_pkg::beat_width-1:0]     wr_data,
  input  logic                               gnt,
  input  logic [vec_pkg::beat_width-1:0]     rd_data,
  output logic                               ld_req,
  input  logic                               ld_valid,
  input  logic [vec_pkg::beat_width-1:0]     ld_data,
  output logic                               st_valid,
  output logic [vec_pkg::beat_width-1:0]     st_data
);
  import vec_pkg::*;
  import vcmd_pkg::*;

  typedef enum logic [1:0] {
    x_idle, x_ld_collect, x_ld_write, x_st_read
  } xfer_state_e;

  xfer_state_e               state_q;
  logic [beat_idx_width-1:0] cnt_q;
  logic                      last_beat;
  logic                      st_last_q;
  logic [reg_addr_width-1:0] vd_q;
  logic [beat_bytes-1:0]     mask_q;
  logic [beat_width-1:0]     buf_q [num_beats];

  assign last_beat = (cnt_q == beat_idx_width'(num_beats - 1));

  assign req     = (state_q == x_ld_write) || (state_q == x_st_read);
  assign rw      = (state_q == x_ld_write);
  assign addr    = vd_q;
  // same mask on every beat
  assign byte_en = mask_q;
  assign wr_data = buf_q[cnt_q];
  // read data lands one cycle after its beat, in step with st_valid
  assign st_data = rd_data;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q   <= x_idle;
      cnt_q     <= '0;
      ld_req    <= 1'b0;
      st_valid  <= 1'b0;
      st_last_q <= 1'b0;
      done      <= 1'b0;
    end else begin
      ld_req    <= 1'b0;
      st_valid  <= gnt && !rw;
      st_last_q <= gnt && !rw && last_beat;
      // load ends after the write burst, store after the last st_valid
      done      <= st_last_q || (gnt && rw && last_beat);
      case (state_q)
        x_idle: begin
          if (start) begin
            cnt_q <= '0;
            if (cmd.op == op_load) begin
              state_q <= x_ld_collect;
              ld_req  <= 1'b1;
            end else begin
              state_q <= x_st_read;
            end
          end
        end
        x_ld_collect: begin
          // beats may come with gaps
          if (ld_valid) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_beat) begin
              state_q <= x_ld_write;
            end
          end
        end
        default: begin
          if (gnt) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_beat) begin
              state_q <= x_idle;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && state_q == x_idle) begin
      vd_q   <= cmd.vd;
      mask_q <= cmd.byte_mask;
    end
    if (state_q == x_ld_collect && ld_valid) begin
      buf_q[cnt_q] <= ld_data;
    end
  end

endmodule

`default_nettype wire

// File: vec_arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vec_arith_unit (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  vcmd_pkg::vcmd_arith_t              cmd,
  output logic                               done,
  output logic                               req,
  output logic                               rw,
  output logic [vec_pkg::reg_addr_width-1:0] addr,
  output logic [vec_pkg::beat_bytes-1:0]     byte_en,
  output logic [vec_pkg::beat_width-1:0]     wr_data,
  input  logic                               gnt,
  input  logic [vec_pkg::beat_width-1:0]     rd_data
);
  import vec_pkg::*;
  import vcmd_pkg::*;

  typedef enum logic [1:0] {
    a_idle, a_rd1, a_rd2, a_wr
  } arith_state_e;

  arith_state_e              state_q;
  logic [beat_idx_width-1:0] cnt_q;
  // read return pipeline
  logic                      cap_q;
  logic                      cap_second_q;
  logic [beat_idx_width-1:0] cap_idx_q;
  logic [reg_addr_width-1:0] vd_q;
  logic [reg_addr_width-1:0] vs1_q;
  logic [reg_addr_width-1:0] vs2_q;
  lane_e                     lane_q;
  logic                      sub_q;
  logic [beat_width-1:0]     buf_q [num_beats];

  // lanes wrap, no carry across lane edges
  function automatic logic [beat_width-1:0] lane_op(
    input logic [beat_width-1:0] a,
    input logic [beat_width-1:0] b,
    input logic                  sub,
    input lane_e                 lane
  );
    logic [beat_width-1:0] r8;
    logic [beat_width-1:0] r32;
    for (int i = 0; i < beat_width / 8; i++) begin
      r8[i*8 +: 8] = sub ? a[i*8 +: 8] - b[i*8 +: 8] : a[i*8 +: 8] + b[i*8 +: 8];
    end
    for (int i = 0; i < beat_width / 32; i++) begin
      r32[i*32 +: 32] = sub ? a[i*32 +: 32] - b[i*32 +: 32] : a[i*32 +: 32] + b[i*32 +: 32];
    end
    return (lane == lane32) ? r32 : r8;
  endfunction

  assign req     = (state_q != a_idle);
  assign rw      = (state_q == a_wr);
  assign byte_en = '1;
  assign wr_data = buf_q[cnt_q];

  always_comb begin
    case (state_q)
      a_rd1:   addr = vs1_q;
      a_rd2:   addr = vs2_q;
      default: addr = vd_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q      <= a_idle;
      cnt_q        <= '0;
      cap_q        <= 1'b0;
      cap_second_q <= 1'b0;
      cap_idx_q    <= '0;
      done         <= 1'b0;
    end else begin
      done         <= 1'b0;
      cap_q        <= gnt && !rw;
      cap_second_q <= (state_q == a_rd2);
      cap_idx_q    <= cnt_q;
      if (state_q == a_idle) begin
        if (start) begin
          state_q <= a_rd1;
          cnt_q   <= '0;
        end
      end else if (gnt) begin
        cnt_q <= cnt_q + 1'b1;
        // next burst after beat 3, req stays up in between
        if (cnt_q == beat_idx_width'(num_beats - 1)) begin
          case (state_q)
            a_rd1:   state_q <= a_rd2;
            a_rd2:   state_q <= a_wr;
            default: begin
              state_q <= a_idle;
              done    <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && state_q == a_idle) begin
      vd_q   <= cmd.vd;
      vs1_q  <= cmd.vs1;
      vs2_q  <= cmd.vs2;
      lane_q <= cmd.lane;
      sub_q  <= (cmd.op == op_sub);
    end
    // vs1 fills the buffer, vs2 folds into it
    if (cap_q) begin
      buf_q[cap_idx_q] <= cap_second_q ? lane_op(buf_q[cap_idx_q], rd_data, sub_q, lane_q)
                                       : rd_data;
    end
  end

endmodule

`default_nettype wire

// File: vec_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module vec_dispatch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmd_start,
  input  vcmd_pkg::vcmd_u       cmd,
  output logic                  xfer_start,
  output vcmd_pkg::vcmd_mem_t   xfer_cmd,
  output logic                  arith_start,
  output vcmd_pkg::vcmd_arith_t arith_cmd,
  input  logic                  xfer_done,
  input  logic                  arith_done,
  output logic                  busy,
  output logic                  done
);
  import vcmd_pkg::*;

  vop_e op;
  logic is_mem;
  logic is_arith;
  logic accept;
  logic busy_q;

  // op decodes the same from either view
  assign op       = cmd.mem.op;
  assign is_mem   = (op == op_load) || (op == op_store);
  assign is_arith = (op == op_add) || (op == op_sub);

  // strobes while busy are dropped, undefined opcodes too
  assign accept = cmd_start && !busy && (is_mem || is_arith);

  assign xfer_start  = accept && is_mem;
  assign arith_start = accept && is_arith;
  assign xfer_cmd    = cmd.mem;
  assign arith_cmd   = cmd.arith;

  // only one unit runs at a time
  assign done = xfer_done || arith_done;
  assign busy = busy_q && !done;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (done) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: vec_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module vec_unit_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cmd_start,
  input  vcmd_pkg::vcmd_u                cmd,
  output logic                           busy,
  output logic                           done,
  output logic                           ld_req,
  input  logic                           ld_valid,
  input  logic [vec_pkg::beat_width-1:0] ld_data,
  output logic                           st_valid,
  output logic [vec_pkg::beat_width-1:0] st_data
);
  import vec_pkg::*;
  import vcmd_pkg::*;

  logic        xfer_start;
  logic        arith_start;
  logic        xfer_done;
  logic        arith_done;
  vcmd_mem_t   xfer_cmd;
  vcmd_arith_t arith_cmd;

  // client side of the arbiter
  logic                      c_req [num_clients];
  logic                      c_rw [num_clients];
  logic [reg_addr_width-1:0] c_addr [num_clients];
  logic [beat_bytes-1:0]     c_byte_en [num_clients];
  logic [beat_width-1:0]     c_wr_data [num_clients];
  logic                      c_gnt [num_clients];

  // register file side
  logic                      rf_en;
  logic                      rf_rw;
  logic [reg_addr_width-1:0] rf_addr;
  logic [beat_bytes-1:0]     rf_byte_en;
  logic [beat_width-1:0]     rf_wr_data;
  logic [beat_width-1:0]     rf_rd_data;
  logic                      rf_active;

  vec_dispatch i_dispatch (
    .clk(clk), .rst(rst), .cmd_start(cmd_start), .cmd(cmd),
    .xfer_start(xfer_start), .xfer_cmd(xfer_cmd),
    .arith_start(arith_start), .arith_cmd(arith_cmd),
    .xfer_done(xfer_done), .arith_done(arith_done), .busy(busy), .done(done)
  );

  vec_xfer_unit i_xfer (
    .clk(clk), .rst(rst), .start(xfer_start), .cmd(xfer_cmd), .done(xfer_done),
    .req(c_req[client_xfer]), .rw(c_rw[client_xfer]), .addr(c_addr[client_xfer]),
    .byte_en(c_byte_en[client_xfer]), .wr_data(c_wr_data[client_xfer]),
    .gnt(c_gnt[client_xfer]), .rd_data(rf_rd_data),
    .ld_req(ld_req), .ld_valid(ld_valid), .ld_data(ld_data),
    .st_valid(st_valid), .st_data(st_data)
  );

  vec_arith_unit i_arith (
    .clk(clk), .rst(rst), .start(arith_start), .cmd(arith_cmd), .done(arith_done),
    .req(c_req[client_arith]), .rw(c_rw[client_arith]), .addr(c_addr[client_arith]),
    .byte_en(c_byte_en[client_arith]), .wr_data(c_wr_data[client_arith]),
    .gnt(c_gnt[client_arith]), .rd_data(rf_rd_data)
  );

  vec_port_arbiter i_arbiter (
    .clk(clk), .rst(rst), .req(c_req), .rw(c_rw), .addr(c_addr),
    .byte_en(c_byte_en), .wr_data(c_wr_data), .gnt(c_gnt),
    .rf_en(rf_en), .rf_rw(rf_rw), .rf_addr(rf_addr), .rf_byte_en(rf_byte_en),
    .rf_wr_data(rf_wr_data), .rf_active(rf_active)
  );

  vec_regfile i_regfile (
    .clk(clk), .rst(rst), .en(rf_en), .rw(rf_rw), .addr(rf_addr),
    .byte_en(rf_byte_en), .wr_data(rf_wr_data), .rd_data(rf_rd_data),
    .active(rf_active)
  );

endmodule

`default_nettype wire

// File: vec_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vec_unit_asserts (
  input logic clk,
  input logic rst,
  input logic req_xfer,
  input logic req_arith,
  input logic gnt_xfer,
  input logic gnt_arith,
  input logic rf_en,
  input logic rf_active
);

  // a grant only goes to a client that is asking for the port
  grant_to_requester: assert property (@(posedge clk) disable iff (!rst)
    (!gnt_xfer || req_xfer) && (!gnt_arith || req_arith))
    else $error("grant given to a client that is not requesting");

  // a grant spans beats 0 to 3 before it drops
  xfer_burst_len: assert property (@(posedge clk) disable iff (!rst)
    $fell(gnt_xfer) |-> ($past(gnt_xfer, 2) && $past(gnt_xfer, 3) &&
                         $past(gnt_xfer, 4)))
    else $error("xfer grant dropped before four beats");

  arith_burst_len: assert property (@(posedge clk) disable iff (!rst)
    $fell(gnt_arith) |-> ($past(gnt_arith, 2) && $past(gnt_arith, 3) &&
                          $past(gnt_arith, 4)))
    else $error("arith grant dropped before four beats");

  // new burst only once the regfile is idle
  no_en_mid_burst: assert property (@(posedge clk) disable iff (!rst)
    !(rf_en && rf_active))
    else $error("rf_en during an active burst");

endmodule

bind vec_port_arbiter vec_unit_asserts i_asserts (
  .clk(clk),
  .rst(rst),
  .req_xfer(req[vec_pkg::client_xfer]),
  .req_arith(req[vec_pkg::client_arith]),
  .gnt_xfer(gnt[vec_pkg::client_xfer]),
  .gnt_arith(gnt[vec_pkg::client_arith]),
  .rf_en(rf_en),
  .rf_active(rf_active)
);

`default_nettype wire

// File: tb_vec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_unit;
  import vec_pkg::*;
  import vcmd_pkg::*;

  localparam int clk_period = 20;
  localparam int num_regs = 1 << reg_addr_width;
  localparam int n_masked = 8;
  localparam int n_arith = 8;
  localparam int n_gap = 4;
  localparam int n_ignore = 2;
  // loads and stores of phase 1, load and store pairs, op plus store,
  // two loads and two stores, op plus two stores
  localparam int total_cmds = 2 * num_regs + 2 * n_masked + 2 * n_arith + 4 * n_gap
                              + 3 * n_ignore;
  // gapped load with up to 3 idle cycles per beat, plus arbitration, burst and done
  localparam int worst_cmd_cycles = 48;
  localparam int watchdog_ns = total_cmds * worst_cmd_cycles * 2 * clk_period;

  logic                  clk;
  logic                  rst;
  logic                  cmd_start;
  vcmd_u                 cmd;
  logic                  busy;
  logic                  done;
  logic                  ld_req;
  logic                  ld_valid;
  logic [beat_width-1:0] ld_data;
  logic                  st_valid;
  logic [beat_width-1:0] st_data;

  // reference copy of the register file with beat k at [k]
  logic [num_beats-1:0][beat_width-1:0] model [num_regs];
  // beats handed to the next load
  logic [beat_width-1:0] ld_buf [num_beats];
  logic [31:0]           lfsr;

  int accepted_cnt;
  int done_cnt;
  int ld_req_cnt;
  int load_cnt;

  vec_unit_top i_dut (
    .clk(clk), .rst(rst), .cmd_start(cmd_start), .cmd(cmd), .busy(busy), .done(done),
    .ld_req(ld_req), .ld_valid(ld_valid), .ld_data(ld_data),
    .st_valid(st_valid), .st_data(st_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // hard stop if a command never finishes
  initial begin
    #(watchdog_ns);
    $display("watchdog timeout, a command never finished");
    $display(">>> FAIL");
    $fatal(1, "watchdog");
  end

  // pulse counters sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      if (done) done_cnt++;
      if (ld_req) ld_req_cnt++;
    end
  end

  // galois lfsr stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // wrap-around lane math on a whole vector
  function automatic logic [vlen-1:0] lane_result(
    input logic [vlen-1:0] a,
    input logic [vlen-1:0] b,
    input bit              sub,
    input lane_e           lane
  );
    logic [vlen-1:0] lmask;
    logic [vlen-1:0] la;
    logic [vlen-1:0] lb;
    logic [vlen-1:0] s;
    logic [vlen-1:0] r;
    int              w;
    w = (lane == lane32) ? 32 : 8;
    lmask = (vlen'(1) << w) - 1'b1;
    r = '0;
    for (int i = 0; i < vlen; i += w) begin
      la = (a >> i) & lmask;
      lb = (b >> i) & lmask;
      s = sub ? la - lb : la + lb;
      // masking drops the carry out of the lane
      r = r | ((s & lmask) << i);
    end
    return r;
  endfunction

  task automatic check_beat(input string name, input logic [beat_width-1:0] exp,
                            input logic [beat_width-1:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "store beat mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      $display("Fail %s expected %0d actual %0d", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic fill_random();
    for (int k = 0; k < num_beats; k++) begin
      ld_buf[k] = rand_bits(beat_width);
    end
  endtask

  // one-cycle strobe once the unit is idle
  task automatic issue_cmd(input vcmd_u c);
    while (busy) @(negedge clk);
    @(posedge clk);
    cmd_start <= 1'b1;
    cmd       <= c;
    @(posedge clk);
    cmd_start <= 1'b0;
    @(negedge clk);
    check_flag("busy after start", 1'b1, busy);
    accepted_cnt++;
  endtask

  task automatic wait_done(input string name);
    do begin
      @(negedge clk);
    end while (!done);
    check_flag({name, " busy at done"}, 1'b0, busy);
  endtask

  task automatic load_vec(input int r, input logic [beat_bytes-1:0] mask, input bit gaps);
    vcmd_u c;
    int    gap;
    c = '0;
    c.mem.op        = op_load;
    c.mem.vd        = r[reg_addr_width-1:0];
    c.mem.byte_mask = mask;
    issue_cmd(c);
    load_cnt++;
    while (!ld_req) @(negedge clk);
    for (int k = 0; k < num_beats; k++) begin
      gap = gaps ? int'(rand_bits(2)) : 0;
      repeat (gap) begin
        @(posedge clk);
        ld_valid <= 1'b0;
      end
      @(posedge clk);
      ld_valid <= 1'b1;
      ld_data  <= ld_buf[k];
    end
    @(posedge clk);
    ld_valid <= 1'b0;
    // only masked bytes change with the same mask on every beat
    for (int k = 0; k < num_beats; k++) begin
      for (int b = 0; b < beat_bytes; b++) begin
        if (mask[b]) model[r][k][b*8 +: 8] = ld_buf[k][b*8 +: 8];
      end
    end
    wait_done("load");
  endtask

  // store r and compare every beat with the model
  task automatic store_check(input int r, input string name);
    vcmd_u c;
    int    n;
    logic  prev;
    c = '0;
    c.mem.op = op_store;
    c.mem.vd = r[reg_addr_width-1:0];
    n = 0;
    prev = 1'b0;
    issue_cmd(c);
    do begin
      @(negedge clk);
      if (st_valid) begin
        if (n > 0) check_flag({name, " st_valid back to back"}, 1'b1, prev);
        if (n < num_beats) begin
          check_beat($sformatf("%s r%0d beat %0d", name, r, n), model[r][n], st_data);
        end
        n++;
      end
      prev = st_valid;
    end while (!done);
    check_count({name, " store beats"}, num_beats, n);
    check_flag({name, " busy at done"}, 1'b0, busy);
  endtask

  task automatic arith_vec(input bit sub, input lane_e lane, input bit stray, input string name);
    vcmd_u c;
    vcmd_u s;
    int    vd;
    int    vs1;
    int    vs2;
    int    sr;
    vd  = int'(rand_bits(reg_addr_width));
    vs1 = int'(rand_bits(reg_addr_width));
    vs2 = int'(rand_bits(reg_addr_width));
    sr  = int'(rand_bits(reg_addr_width));
    c = '0;
    c.arith.op   = sub ? op_sub : op_add;
    c.arith.vd   = vd[reg_addr_width-1:0];
    c.arith.vs1  = vs1[reg_addr_width-1:0];
    c.arith.vs2  = vs2[reg_addr_width-1:0];
    c.arith.lane = lane;
    issue_cmd(c);
    if (stray) begin
      // load strobe in the middle of the op that must be dropped
      s = '0;
      s.mem.op        = op_load;
      s.mem.vd        = sr[reg_addr_width-1:0];
      s.mem.byte_mask = '1;
      @(posedge clk);
      cmd_start <= 1'b1;
      cmd       <= s;
      @(posedge clk);
      cmd_start <= 1'b0;
    end
    wait_done(name);
    model[vd] = lane_result(model[vs1], model[vs2], sub, lane);
    store_check(vd, name);
    if (stray) store_check(sr, {name, " stray target"});
  endtask

  initial begin
    int ra;
    int rb;
    lfsr         = 32'he141_5e5d;
    rst          = 1'b0;
    cmd_start    = 1'b0;
    cmd          = '0;
    ld_valid     = 1'b0;
    ld_data      = '0;
    accepted_cnt = 0;
    done_cnt     = 0;
    ld_req_cnt   = 0;
    load_cnt     = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset done", 1'b0, done);
    check_flag("reset ld_req", 1'b0, ld_req);
    check_flag("reset st_valid", 1'b0, st_valid);

    // every register gets a full load first so nothing reads garbage later
    for (int r = 0; r < num_regs; r++) begin
      fill_random();
      load_vec(r, '1, 1'b0);
    end
    for (int r = 0; r < num_regs; r++) begin
      store_check(r, "full load");
    end

    for (int i = 0; i < n_masked; i++) begin
      ra = int'(rand_bits(reg_addr_width));
      fill_random();
      load_vec(ra, beat_bytes'(rand_bits(beat_bytes)), 1'b0);
      store_check(ra, "masked load");
    end

    // add on 8-bit lanes, sub on 32-bit lanes
    for (int i = 0; i < n_arith; i++) begin
      if (i % 2 == 0) arith_vec(1'b0, lane8, 1'b0, "add8");
      else arith_vec(1'b1, lane32, 1'b0, "sub32");
    end

    // same beats once back to back and once with gaps
    for (int i = 0; i < n_gap; i++) begin
      ra = int'(rand_bits(reg_addr_width));
      rb = (ra + 1 + int'(rand_bits(4))) % num_regs;
      fill_random();
      load_vec(ra, '1, 1'b0);
      load_vec(rb, '1, 1'b1);
      store_check(ra, "back to back load");
      store_check(rb, "gapped load");
    end

    for (int i = 0; i < n_ignore; i++) begin
      arith_vec(1'b0, lane8, 1'b1, "add under stray strobe");
    end

    // let the last done reach the counter
    repeat (2) @(posedge clk);
    check_count("done pulses", accepted_cnt, done_cnt);
    check_count("ld_req pulses", load_cnt, ld_req_cnt);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
vec_pkg.sv
vcmd_pkg.sv
vec_regfile.sv
vec_port_arbiter.sv
vec_xfer_unit.sv
vec_arith_unit.sv
vec_dispatch.sv
vec_unit_top.sv
vec_unit_asserts.sv
tb_vec_unit.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_vec_unit
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q ">>> PASS" $(LOG) && ! grep -q ">>> FAIL" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
